// ==== source/dataflowPkg.sv ====
package dataflowPkg;

  // Operand and result widths
  localparam int operandWidth = 16;
  localparam int resultWidth = 32;

  // Slots in the pair FIFO branch
  localparam int pairDepth = 4;

  // Slots in the product buffer behind the multiplier
  localparam int productDepth = 2;

  // Register stages in the multiplier ahead of its buffer
  localparam int mulStages = 2;

  // Operand token as it enters the kernel
  typedef struct packed {
    logic [operandWidth-1:0] a;
    logic [operandWidth-1:0] b;
  } operandPair_t;

endpackage

// ==== source/elasticFifo.sv ====
`timescale 1ns/10ps

module elasticFifo #(
  parameter int numSlots = 2,
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t ins,
  input  logic     insValid,
  output logic     insReady,
  output payload_t outs,
  output logic     outsValid,
  input  logic     outsReady
);

  // Storage and circular indices
  payload_t mem [numSlots];
  logic [$clog2(numSlots)-1:0] head;
  logic [$clog2(numSlots)-1:0] tail;
  logic [$clog2(numSlots)-1:0] headNext;
  logic [$clog2(numSlots)-1:0] tailNext;

  logic full;
  logic empty;
  logic readEn;
  logic writeEn;

  // Indices wrap on their own since numSlots is a power of two
  assign headNext = head + 1'b1;
  assign tailNext = tail + 1'b1;

  // A full buffer still takes a word when the consumer reads this cycle
  assign insReady = ~full | outsReady;
  assign writeEn = insValid & (~full | outsReady);
  assign readEn = outsReady & ~empty;

  assign outsValid = ~empty;
  assign outs = mem[head];

  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[tail] <= ins;
    end
  end

  // Write pointer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tail <= '0;
    end else if (writeEn) begin
      tail <= tailNext;
    end
  end

  // Read pointer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      head <= '0;
    end else if (readEn) begin
      head <= headNext;
    end
  end

  // Full only changes when filling without draining or the reverse
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      full <= 1'b0;
    end else begin
      if (writeEn & ~readEn) begin
        if (tailNext == head) begin
          full <= 1'b1;
        end
      end else if (~writeEn & readEn) begin
        full <= 1'b0;
      end
    end
  end

  // Empty follows the same rule from the other side
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      empty <= 1'b1;
    end else begin
      if (~writeEn & readEn) begin
        if (headNext == tail) begin
          empty <= 1'b1;
        end
      end else if (writeEn & ~readEn) begin
        empty <= 1'b0;
      end
    end
  end

endmodule

// ==== source/tokenFork.sv ====
`timescale 1ns/10ps

module tokenFork (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     inValid,
  input  dataflowPkg::operandPair_t inData,
  output logic                     inReady,
  output logic                     mulValid,
  output dataflowPkg::operandPair_t mulData,
  input  logic                     mulReady,
  output logic                     pairValid,
  output dataflowPkg::operandPair_t pairData,
  input  logic                     pairReady
);

  // Set once a branch has taken the current token
  logic mulDone;
  logic pairDone;
  // Goes high on the first edge after reset is released
  logic started;
  logic inFire;

  // Both branches see the same token
  assign mulData = inData;
  assign pairData = inData;

  assign mulValid = started & inValid & ~mulDone;
  assign pairValid = started & inValid & ~pairDone;

  // Input completes when every branch is served now or earlier
  assign inReady = started & (mulDone | mulReady) & (pairDone | pairReady);
  assign inFire = inValid & inReady;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      started <= 1'b0;
    end else begin
      started <= 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mulDone <= 1'b0;
      pairDone <= 1'b0;
    end else if (inFire) begin
      mulDone <= 1'b0;
      pairDone <= 1'b0;
    end else begin
      if (mulValid & mulReady) begin
        mulDone <= 1'b1;
      end
      if (pairValid & pairReady) begin
        pairDone <= 1'b1;
      end
    end
  end

endmodule

// ==== source/mulPipe.sv ====
`timescale 1ns/10ps

module mulPipe (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                opValid,
  input  dataflowPkg::operandPair_t            opData,
  output logic                                opReady,
  output logic                                prodValid,
  output logic [dataflowPkg::resultWidth-1:0] prodData,
  input  logic                                prodReady
);

  // Stage 0 holds the operands, later stages hold the product
  dataflowPkg::operandPair_t opStage;
  logic [dataflowPkg::resultWidth-1:0] prodStage [1:dataflowPkg::mulStages-1];
  logic [dataflowPkg::resultWidth-1:0] mulResult;

  logic [dataflowPkg::mulStages-1:0] stageValid;
  logic [dataflowPkg::mulStages-1:0] stageAdvance;
  logic bufReady;

  // Full width product of the registered operands
  assign mulResult = opStage.a * opStage.b;

  // A stage moves when it is empty or the stage after it moves
  always_comb begin
    stageAdvance[dataflowPkg::mulStages-1] = ~stageValid[dataflowPkg::mulStages-1] | bufReady;
    for (int i = dataflowPkg::mulStages - 2; i >= 0; i--) begin
      stageAdvance[i] = ~stageValid[i] | stageAdvance[i+1];
    end
  end

  assign opReady = stageAdvance[0];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stageValid <= '0;
    end else begin
      if (stageAdvance[0]) begin
        stageValid[0] <= opValid;
      end
      for (int i = 1; i < dataflowPkg::mulStages; i++) begin
        if (stageAdvance[i]) begin
          stageValid[i] <= stageValid[i-1];
        end
      end
    end
  end

  // Payload registers load only when a token actually moves in
  always_ff @(posedge clk) begin
    if (stageAdvance[0] & opValid) begin
      opStage <= opData;
    end
    if (stageAdvance[1] & stageValid[0]) begin
      prodStage[1] <= mulResult;
    end
    for (int i = 2; i < dataflowPkg::mulStages; i++) begin
      if (stageAdvance[i] & stageValid[i-1]) begin
        prodStage[i] <= prodStage[i-1];
      end
    end
  end

  // Buffer absorbs products while the join is waiting on the pair branch
  elasticFifo #(
    .numSlots (dataflowPkg::productDepth),
    .payload_t(logic [dataflowPkg::resultWidth-1:0])
  ) productBuf (
    .clk      (clk),
    .rst      (rst),
    .ins      (prodStage[dataflowPkg::mulStages-1]),
    .insValid (stageValid[dataflowPkg::mulStages-1]),
    .insReady (bufReady),
    .outs     (prodData),
    .outsValid(prodValid),
    .outsReady(prodReady)
  );

endmodule

// ==== source/tokenJoin.sv ====
`timescale 1ns/10ps

module tokenJoin (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                prodValid,
  input  logic [dataflowPkg::resultWidth-1:0] prodData,
  output logic                                prodReady,
  input  logic                                pairValid,
  input  dataflowPkg::operandPair_t            pairData,
  output logic                                pairReady,
  output logic                                resValid,
  output logic [dataflowPkg::resultWidth-1:0] resData,
  input  logic                                resReady
);

  logic [dataflowPkg::operandWidth-1:0] absDiff;
  logic [dataflowPkg::resultWidth-1:0] sum;
  logic outFree;
  logic fire;

  // Output register can load when empty or being drained
  assign outFree = ~resValid | resReady;

  // Both inputs are consumed together or not at all
  assign fire = prodValid & pairValid & outFree;
  assign prodReady = fire;
  assign pairReady = fire;

  // Unsigned distance between the two operands
  always_comb begin
    if (pairData.a >= pairData.b) begin
      absDiff = pairData.a - pairData.b;
    end else begin
      absDiff = pairData.b - pairData.a;
    end
  end

  // Wraps modulo 2^32
  assign sum = prodData + {{(dataflowPkg::resultWidth - dataflowPkg::operandWidth){1'b0}}, absDiff};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      resValid <= 1'b0;
    end else if (fire) begin
      resValid <= 1'b1;
    end else if (resReady) begin
      resValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      resData <= sum;
    end
  end

endmodule

// ==== source/dataflowKernel.sv ====
`timescale 1ns/10ps

module dataflowKernel (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                inValid,
  input  dataflowPkg::operandPair_t            inData,
  output logic                                inReady,
  output logic                                resValid,
  output logic [dataflowPkg::resultWidth-1:0] resData,
  input  logic                                resReady
);

  // Fork to multiplier branch
  logic                      mulValid;
  dataflowPkg::operandPair_t mulData;
  logic                      mulReady;

  // Fork to pair FIFO branch
  logic                      pairValid;
  dataflowPkg::operandPair_t pairData;
  logic                      pairReady;

  // Branch outputs into the join
  logic                                prodValid;
  logic [dataflowPkg::resultWidth-1:0] prodData;
  logic                                prodReady;
  logic                                qValid;
  dataflowPkg::operandPair_t            qData;
  logic                                qReady;

  tokenFork fork0 (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inData   (inData),
    .inReady  (inReady),
    .mulValid (mulValid),
    .mulData  (mulData),
    .mulReady (mulReady),
    .pairValid(pairValid),
    .pairData (pairData),
    .pairReady(pairReady)
  );

  mulPipe mul0 (
    .clk      (clk),
    .rst      (rst),
    .opValid  (mulValid),
    .opData   (mulData),
    .opReady  (mulReady),
    .prodValid(prodValid),
    .prodData (prodData),
    .prodReady(prodReady)
  );

  // Keeps the operands around until the product catches up
  elasticFifo #(
    .numSlots (dataflowPkg::pairDepth),
    .payload_t(dataflowPkg::operandPair_t)
  ) pairFifo (
    .clk      (clk),
    .rst      (rst),
    .ins      (pairData),
    .insValid (pairValid),
    .insReady (pairReady),
    .outs     (qData),
    .outsValid(qValid),
    .outsReady(qReady)
  );

  tokenJoin join0 (
    .clk      (clk),
    .rst      (rst),
    .prodValid(prodValid),
    .prodData (prodData),
    .prodReady(prodReady),
    .pairValid(qValid),
    .pairData (qData),
    .pairReady(qReady),
    .resValid (resValid),
    .resData  (resData),
    .resReady (resReady)
  );

endmodule

// ==== tests/dataflowKernel_assertions.sv ====
`timescale 1ns/10ps

module dataflowKernel_assertions (
  input logic                                clk,
  input logic                                rst,
  input logic                                inReady,
  input logic                                resValid,
  input logic [dataflowPkg::resultWidth-1:0] resData,
  input logic                                resReady
);

  // A result waiting on the consumer must not change or vanish
  resultHeld: assert property (
    @(posedge clk) disable iff (rst)
    (resValid && !resReady) |=> (resValid && $stable(resData))
  ) else $error("resValid or resData changed while the output was stalled");

  // No operand may be taken while the kernel is in reset
  noInputDuringReset: assert property (@(posedge clk) rst |-> !inReady)
    else $error("inReady was high during reset");

  // Output stage comes out of reset empty
  idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> !resValid)
    else $error("resValid was high in the first cycle after reset");

endmodule

// Attach to every kernel instance
bind dataflowKernel dataflowKernel_assertions handshakeChecks (
  .clk     (clk),
  .rst     (rst),
  .inReady (inReady),
  .resValid(resValid),
  .resData (resData),
  .resReady(resReady)
);

// ==== tests/dataflowKernelTb.sv ====
`timescale 1ns/10ps

module dataflowKernelTb;

  localparam int opW = dataflowPkg::operandWidth;
  localparam int resW = dataflowPkg::resultWidth;
  localparam int tableSize = 11;
  localparam int randomCount = 200;
  localparam int handshakeLimit = 100;
  localparam int drainLimit = 2000;

  logic clk;
  logic rst;
  logic inValid;
  dataflowPkg::operandPair_t inData;
  logic inReady;
  logic resValid;
  logic [resW-1:0] resData;
  logic resReady;

  // Operand table with hand-worked results
  logic [opW-1:0] tableA [tableSize] = '{0, 0, 7, 3, 10, 1000, 65535, 65535, 65535, 256, 12345};
  logic [opW-1:0] tableB [tableSize] = '{0, 5, 7, 10, 3, 2000, 65535, 0, 1, 255, 54321};
  logic [resW-1:0] tableResult [tableSize] = '{
    32'd0, 32'd5, 32'd49, 32'd37, 32'd37, 32'd2001000,
    32'd4294836225, 32'd65535, 32'd131069, 32'd65281, 32'd670634721
  };

  // Random operands drawn before the random phase starts
  logic [opW-1:0] randA [randomCount];
  logic [opW-1:0] randB [randomCount];
  bit randGap [randomCount];

  // In-order scoreboard
  logic [resW-1:0] expectedQueue [$];
  string nameQueue [$];
  logic [resW-1:0] pendingExpected;
  string pendingName;

  int seed = 98832;
  int sentCount = 0;
  int recvCount = 0;
  int cycleCount = 0;
  int lastResCycle = -1;
  int gapCount = 0;
  bit gapCheck = 1'b0;
  bit randomStall = 1'b0;

  dataflowKernel UUT (
    .clk     (clk),
    .rst     (rst),
    .inValid (inValid),
    .inData  (inData),
    .inReady (inReady),
    .resValid(resValid),
    .resData (resData),
    .resReady(resReady)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
  end

  // Random back-pressure on the result channel
  always @(posedge clk) begin
    #2;
    if (randomStall) begin
      resReady = (($random(seed) & 3) != 0);
    end
  end

  function automatic logic [resW-1:0] expectedResult(input logic [opW-1:0] a,
                                                     input logic [opW-1:0] b);
    logic [resW-1:0] product;
    logic [resW-1:0] distance;
    product = {{(resW - opW){1'b0}}, a} * {{(resW - opW){1'b0}}, b};
    if (a >= b) begin
      distance = a - b;
    end else begin
      distance = b - a;
    end
    return product + distance;
  endfunction

  task automatic stopWithError(input string reason);
    $display("ERROR: %s", reason);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [resW-1:0] expected,
                            input logic [resW-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at first mismatch");
    end
  endtask

  // Holds the token on the input until taken or the limit runs out
  task automatic offerToken(input logic [opW-1:0] a, input logic [opW-1:0] b,
                            input logic [resW-1:0] expected, input string name,
                            input int limit, output bit taken);
    int waited;
    inValid = 1'b1;
    inData.a = a;
    inData.b = b;
    pendingExpected = expected;
    pendingName = name;
    taken = 1'b0;
    waited = 0;
    while (!taken && waited < limit) begin
      @(negedge clk);
      if (inReady) begin
        taken = 1'b1;
      end
      waited++;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic sendToken(input logic [opW-1:0] a, input logic [opW-1:0] b,
                           input logic [resW-1:0] expected, input string name);
    bit taken;
    offerToken(a, b, expected, name, handshakeLimit, taken);
    if (!taken) begin
      stopWithError($sformatf("inReady stayed low, operand token for %s was never taken", name));
    end
  endtask

  task automatic idleInput();
    inValid = 1'b0;
    @(posedge clk);
    #2;
  endtask

  task automatic waitResults(input string what);
    int waited;
    waited = 0;
    while (recvCount != sentCount && waited < drainLimit) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (recvCount != sentCount) begin
      stopWithError($sformatf("results of %s did not all come out in time", what));
    end
  endtask

  // Handshakes are stable at the falling edge and complete on the next rising edge
  always @(negedge clk) begin
    if (!rst) begin
      if (inValid && inReady) begin
        expectedQueue.push_back(pendingExpected);
        nameQueue.push_back(pendingName);
        sentCount++;
      end
      if (resValid && resReady) begin
        if (expectedQueue.size() == 0) begin
          stopWithError("a result came out with no operand token outstanding");
        end else begin
          checkValue(nameQueue.pop_front(), expectedQueue.pop_front(), resData);
          if (gapCheck && lastResCycle >= 0 && cycleCount != lastResCycle + 1) begin
            gapCount++;
          end
          lastResCycle = cycleCount;
          recvCount++;
        end
      end
    end
  end

  initial begin
    logic [opW-1:0] a;
    logic [opW-1:0] b;
    bit taken;
    bit stallSeen;
    clk = 1'b0;
    rst = 1'b1;
    inValid = 1'b0;
    inData = '0;
    resReady = 1'b0;
    pendingExpected = '0;
    pendingName = "none";
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    // Nothing comes out before anything goes in
    repeat (3) begin
      @(negedge clk);
      checkValue("resValid idle after reset", 0, resValid);
    end
    @(posedge clk);
    #2;

    // Table entries one at a time with the consumer always ready
    resReady = 1'b1;
    for (int i = 0; i < tableSize; i++) begin
      sendToken(tableA[i], tableB[i], tableResult[i], $sformatf("table entry %0d", i));
      idleInput();
    end
    waitResults("table");

    // Stalled consumer until the input side backs up
    resReady = 1'b0;
    stallSeen = 1'b0;
    a = '0;
    b = '0;
    for (int i = 0; i < 16 && !stallSeen; i++) begin
      a = i * 4099 + 3;
      b = 16'hffff - i * 77;
      offerToken(a, b, expectedResult(a, b), "back-pressure", 10, taken);
      if (!taken) begin
        stallSeen = 1'b1;
      end
    end
    checkValue("inReady drops under back-pressure", 1, stallSeen);
    resReady = 1'b1;
    // The blocked token is still on the input and goes through now
    sendToken(a, b, expectedResult(a, b), "back-pressure");
    idleInput();
    waitResults("back-pressure");

    // Random operands with random stalls on the result side
    for (int i = 0; i < randomCount; i++) begin
      randA[i] = $random(seed);
      randB[i] = $random(seed);
      randGap[i] = (($random(seed) & 7) == 0);
    end
    randomStall = 1'b1;
    for (int i = 0; i < randomCount; i++) begin
      sendToken(randA[i], randB[i], expectedResult(randA[i], randB[i]),
                $sformatf("random token %0d", i));
      if (randGap[i]) begin
        idleInput();
      end
    end
    idleInput();
    randomStall = 1'b0;
    resReady = 1'b1;
    waitResults("random phase");

    // Back-to-back burst must stream out without bubbles
    gapCount = 0;
    lastResCycle = -1;
    gapCheck = 1'b1;
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < tableSize; i++) begin
        sendToken(tableA[i], tableB[i], tableResult[i], $sformatf("burst entry %0d", i));
      end
    end
    idleInput();
    waitResults("back-to-back burst");
    gapCheck = 1'b0;
    checkValue("gaps between back-to-back results", 0, gapCount);

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
source/dataflowPkg.sv
source/elasticFifo.sv
source/tokenFork.sv
source/mulPipe.sv
source/tokenJoin.sv
source/dataflowKernel.sv
tests/dataflowKernel_assertions.sv
tests/dataflowKernelTb.sv

// ==== Bender.yml ====
package:
  name: dataflow_kernel

sources:
  # Package first, then modules in dependency order
  - source/dataflowPkg.sv
  - source/elasticFifo.sv
  - source/tokenFork.sv
  - source/mulPipe.sv
  - source/tokenJoin.sv
  - source/dataflowKernel.sv

  # Testbench files, bound checks ahead of the top module
  - target: test
    files:
      - tests/dataflowKernel_assertions.sv
      - tests/dataflowKernelTb.sv
